//--- hw/xip_pkg.sv
// shared widths, register map, control-field positions and fetch FSM states for the XIP controller
`default_nettype none

package xip_pkg;

    // ----------------------------------------
    // widths with a meaning
    typedef logic [31:0] word_t;    // bus / register word
    typedef logic [3:0]  page_t;    // xip page, matches addr[31:28]
    typedef logic [7:0]  cmd_t;     // flash read command
    typedef logic [3:0]  nbytes_t;  // bytes per transfer, 1..9
    typedef logic [1:0]  abytes_t;  // address bytes minus one
    typedef logic [2:0]  prsc_t;    // prescaler select
    typedef logic [1:0]  reg_idx_t; // control port word index

    // ----------------------------------------
    // register map
    localparam reg_idx_t reg_ctrl_c    = 2'd0; // control / status
    localparam reg_idx_t reg_data_lo_c = 2'd2; // direct data low, rx data on read
    localparam reg_idx_t reg_data_hi_c = 2'd3; // direct data high, write fires transfer

    // ----------------------------------------
    // control register bit positions
    localparam int ctrl_enable_c     = 0;  // module enable
    localparam int ctrl_prsc_lo_c    = 1;  // prescaler, 3 bits
    localparam int ctrl_nbytes_lo_c  = 6;  // transfer length, 4 bits
    localparam int ctrl_xip_enable_c = 10; // fetch engine owns the phy
    localparam int ctrl_abytes_lo_c  = 11; // address bytes code, 2 bits
    localparam int ctrl_rd_cmd_lo_c  = 13; // read command, 8 bits
    localparam int ctrl_page_lo_c    = 21; // xip page, 4 bits
    localparam int ctrl_phy_busy_c   = 30; // read-only
    localparam int ctrl_xip_busy_c   = 31; // read-only

    // fetch engine states
    typedef enum logic [1:0] {
        f_idle,
        f_trig,
        f_busy,
        f_error
    } fetch_state_t;

endpackage

`default_nettype wire

//--- hw/xip_ctrl_regs.sv
// control-port register file: holds the configuration fields and fires direct SPI transfers
`timescale 1ns/1ps
`default_nettype none

module xip_ctrl_regs #(
    parameter int FRAME_BYTES = 9 // phy frame size in bytes
) (
    input  wire                     clk_i,
    input  wire                     rstn_i,
    input  wire xip_pkg::reg_idx_t  ct_addr_i,      // word index
    input  wire                     ct_rden_i,
    input  wire                     ct_wren_i,
    input  wire xip_pkg::word_t     ct_data_i,
    output xip_pkg::word_t          ct_data_o,
    output logic                    ct_ack_o,
    input  wire                     phy_busy_i,     // readback only
    input  wire                     xip_busy_i,     // readback only
    input  wire xip_pkg::word_t     phy_rdata_i,    // last 32 rx bits
    output logic                    enable_o,
    output xip_pkg::prsc_t          prsc_o,
    output xip_pkg::nbytes_t        nbytes_o,
    output logic                    xip_enable_o,
    output xip_pkg::abytes_t        abytes_o,
    output xip_pkg::cmd_t           rd_cmd_o,
    output xip_pkg::page_t          page_o,
    output logic                    direct_start_o, // one-cycle pulse
    output logic [FRAME_BYTES*8-1:0] direct_frame_o
);

    xip_pkg::word_t data_lo_q; // direct tx data, second word
    xip_pkg::word_t data_hi_q; // direct tx data, first word out
    xip_pkg::word_t ctrl_rd;   // control register readback image

    // ----------------------------------------
    // write side
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            enable_o       <= 1'b0;
            prsc_o         <= '0;
            nbytes_o       <= '0;
            xip_enable_o   <= 1'b0;
            abytes_o       <= '0;
            rd_cmd_o       <= '0;
            page_o         <= '0;
            data_lo_q      <= '0;
            data_hi_q      <= '0;
            direct_start_o <= 1'b0;
        end else begin
            direct_start_o <= 1'b0; // pulse only
            if (ct_wren_i) begin
                if (ct_addr_i == xip_pkg::reg_ctrl_c) begin // dropped bits not kept
                    enable_o     <= ct_data_i[xip_pkg::ctrl_enable_c];
                    prsc_o       <= ct_data_i[xip_pkg::ctrl_prsc_lo_c +: 3];
                    nbytes_o     <= ct_data_i[xip_pkg::ctrl_nbytes_lo_c +: 4];
                    xip_enable_o <= ct_data_i[xip_pkg::ctrl_xip_enable_c];
                    abytes_o     <= ct_data_i[xip_pkg::ctrl_abytes_lo_c +: 2];
                    rd_cmd_o     <= ct_data_i[xip_pkg::ctrl_rd_cmd_lo_c +: 8];
                    page_o       <= ct_data_i[xip_pkg::ctrl_page_lo_c +: 4];
                end
                if (ct_addr_i == xip_pkg::reg_data_lo_c) begin
                    data_lo_q <= ct_data_i;
                end
                if (ct_addr_i == xip_pkg::reg_data_hi_c) begin
                    data_hi_q      <= ct_data_i;
                    direct_start_o <= 1'b1; // kick direct transfer
                end
            end
        end
    end

    // ----------------------------------------
    // read side
    always_comb begin
        ctrl_rd                                      = '0;
        ctrl_rd[xip_pkg::ctrl_enable_c]              = enable_o;
        ctrl_rd[xip_pkg::ctrl_prsc_lo_c +: 3]        = prsc_o;
        ctrl_rd[xip_pkg::ctrl_nbytes_lo_c +: 4]      = nbytes_o;
        ctrl_rd[xip_pkg::ctrl_xip_enable_c]          = xip_enable_o;
        ctrl_rd[xip_pkg::ctrl_abytes_lo_c +: 2]      = abytes_o;
        ctrl_rd[xip_pkg::ctrl_rd_cmd_lo_c +: 8]      = rd_cmd_o;
        ctrl_rd[xip_pkg::ctrl_page_lo_c +: 4]        = page_o;
        ctrl_rd[xip_pkg::ctrl_phy_busy_c]            = phy_busy_i;
        ctrl_rd[xip_pkg::ctrl_xip_busy_c]            = xip_busy_i;
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            ct_ack_o  <= 1'b0;
            ct_data_o <= '0;
        end else begin
            ct_ack_o  <= ct_rden_i | ct_wren_i; // ack every access
            ct_data_o <= '0;                    // zero unless reading
            if (ct_rden_i) begin
                case (ct_addr_i)
                    xip_pkg::reg_ctrl_c:    ct_data_o <= ctrl_rd;
                    xip_pkg::reg_data_lo_c: ct_data_o <= phy_rdata_i; // rx data
                    default:                ct_data_o <= '0;          // data high is write-only
                endcase
            end
        end
    end

    // msb first: high word, low word, then zero pad
    assign direct_frame_o = {data_hi_q, data_lo_q, {(FRAME_BYTES*8-64){1'b0}}};

endmodule

`default_nettype wire

//--- hw/xip_fetch.sv
// fetch engine: turns page-hit reads into flash read frames and returns little-endian words
`timescale 1ns/1ps
`default_nettype none

module xip_fetch #(
    parameter int FRAME_BYTES = 9 // phy frame size in bytes
) (
    input  wire                      clk_i,
    input  wire                      rstn_i,
    input  wire xip_pkg::word_t      acc_addr_i,
    input  wire                      acc_rden_i,
    input  wire                      acc_wren_i,
    output xip_pkg::word_t           acc_data_o,
    output logic                     acc_ack_o,
    output logic                     acc_err_o,
    input  wire                      active_i,    // enable and xip_enable
    input  wire xip_pkg::page_t      page_i,
    input  wire xip_pkg::abytes_t    abytes_i,
    input  wire xip_pkg::cmd_t       rd_cmd_i,
    input  wire                      phy_busy_i,
    input  wire xip_pkg::word_t      phy_rdata_i,
    output logic                     busy_o,
    output logic                     start_o,
    output logic [FRAME_BYTES*8-1:0] frame_o
);

    xip_pkg::fetch_state_t state_q;
    xip_pkg::word_t        addr_q;     // latched request address
    xip_pkg::word_t        aligned;    // word aligned, page bits stripped
    xip_pkg::word_t        flash_addr; // address bytes, left aligned
    logic                  page_hit;

    assign page_hit = (acc_addr_i[31:28] == page_i);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q   <= xip_pkg::f_idle;
            addr_q    <= '0;
            acc_err_o <= 1'b0;
        end else if (!active_i) begin
            state_q   <= xip_pkg::f_idle; // parked while disabled
            acc_err_o <= 1'b0;
        end else begin
            acc_err_o <= 1'b0;
            case (state_q)
                xip_pkg::f_idle: begin
                    if (page_hit && acc_rden_i) begin
                        addr_q  <= acc_addr_i;
                        state_q <= xip_pkg::f_trig;
                    end else if (page_hit && acc_wren_i) begin
                        state_q <= xip_pkg::f_error; // read-only space
                    end
                end
                xip_pkg::f_trig:  state_q <= xip_pkg::f_busy;
                xip_pkg::f_busy: begin
                    if (!phy_busy_i) begin
                        state_q <= xip_pkg::f_idle; // done, ack this cycle
                    end
                end
                xip_pkg::f_error: begin
                    acc_err_o <= ~acc_err_o;    // two cycles here, err on the second
                    if (acc_err_o) begin
                        state_q <= xip_pkg::f_idle;
                    end
                end
                default: state_q <= xip_pkg::f_idle;
            endcase
        end
    end

    // ----------------------------------------
    // frame: cmd, address bytes, zero data
    always_comb begin
        aligned = {4'h0, addr_q[27:2], 2'b00};
        case (abytes_i)
            2'd0:    flash_addr = {aligned[7:0], 24'h0};
            2'd1:    flash_addr = {aligned[15:0], 16'h0};
            2'd2:    flash_addr = {aligned[23:0], 8'h0};
            default: flash_addr = aligned; // 4 address bytes
        endcase
    end

    assign frame_o   = {rd_cmd_i, flash_addr, {(FRAME_BYTES*8-40){1'b0}}};
    assign start_o   = (state_q == xip_pkg::f_trig);
    assign busy_o    = (state_q == xip_pkg::f_trig) || (state_q == xip_pkg::f_busy);
    assign acc_ack_o = (state_q == xip_pkg::f_busy) && !phy_busy_i;

    // first byte on the wire is the lowest address
    assign acc_data_o = (state_q == xip_pkg::f_busy) ?
                        {phy_rdata_i[7:0], phy_rdata_i[15:8],
                         phy_rdata_i[23:16], phy_rdata_i[31:24]} : '0;

endmodule

`default_nettype wire

//--- hw/xip_phy_arbiter.sv
// SPI PHY ownership arbiter between the direct requester and the fetch engine
`timescale 1ns/1ps
`default_nettype none

module xip_phy_arbiter #(
    parameter int FRAME_BYTES = 9 // phy frame size in bytes
) (
    input  wire                      clk_i,
    input  wire                      rstn_i,
    input  wire                      xip_enable_i,   // wanted owner, 1 = fetch
    input  wire                      phy_busy_i,
    input  wire                      direct_start_i,
    input  wire [FRAME_BYTES*8-1:0]  direct_frame_i,
    input  wire                      fetch_start_i,
    input  wire [FRAME_BYTES*8-1:0]  fetch_frame_i,
    output logic                     phy_start_o,
    output logic [FRAME_BYTES*8-1:0] phy_frame_o
);

    logic owner_fetch_q; // current owner, 1 = fetch engine

    // switch only between transfers
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            owner_fetch_q <= 1'b0; // direct owns after reset
        end else if (!phy_busy_i && !phy_start_o) begin
            owner_fetch_q <= xip_enable_i;
        end
    end

    // non-owner starts are dropped
    assign phy_start_o = owner_fetch_q ? fetch_start_i : direct_start_i;
    assign phy_frame_o = owner_fetch_q ? fetch_frame_i : direct_frame_i;

endmodule

`default_nettype wire

//--- hw/xip_spi_phy.sv
// mode-0 SPI shift engine with clock prescaler and per-transfer chip select
`timescale 1ns/1ps
`default_nettype none

module xip_spi_phy #(
    parameter int FRAME_BYTES = 9 // shift register size in bytes
) (
    input  wire                     clk_i,
    input  wire                     rstn_i,
    input  wire                     enable_i,  // sync clear when low
    input  wire xip_pkg::prsc_t     prsc_i,
    input  wire xip_pkg::nbytes_t   nbytes_i,
    input  wire                     start_i,
    input  wire [FRAME_BYTES*8-1:0] frame_i,   // msb first
    output logic                    busy_o,
    output xip_pkg::word_t          rdata_o,   // last 32 bits in
    output logic                    spi_csn_o,
    output logic                    spi_clk_o,
    input  wire                     spi_dat_i,
    output logic                    spi_dat_o
);

    typedef enum logic [1:0] {
        s_idle,
        s_low,   // sclk low half
        s_high,  // sclk high half
        s_end    // cs hold before release
    } phy_state_t;

    phy_state_t               state_q;
    logic [FRAME_BYTES*8-1:0] sreg_q;     // tx shift register
    logic [6:0]               bit_cnt_q;  // bits still to shift
    logic [7:0]               prsc_cnt_q; // half period counter
    logic [7:0]               half_last;  // 2^(prsc+1) - 1
    logic                     tick;       // end of half period

    assign half_last = 8'((9'd2 << prsc_i) - 9'd1);
    assign tick      = (prsc_cnt_q == half_last);
    assign spi_dat_o = sreg_q[FRAME_BYTES*8-1]; // changes after falling edge

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q    <= s_idle;
            sreg_q     <= '0;
            bit_cnt_q  <= '0;
            prsc_cnt_q <= '0;
            rdata_o    <= '0;
            busy_o     <= 1'b0;
            spi_csn_o  <= 1'b1;
            spi_clk_o  <= 1'b0;
        end else if (!enable_i) begin
            state_q    <= s_idle;
            sreg_q     <= '0;
            bit_cnt_q  <= '0;
            prsc_cnt_q <= '0;
            rdata_o    <= '0;
            busy_o     <= 1'b0;
            spi_csn_o  <= 1'b1;
            spi_clk_o  <= 1'b0;
        end else begin
            // ----------------------------------------
            // prescaler, runs only during a transfer
            if (state_q == s_idle || tick) begin
                prsc_cnt_q <= '0;
            end else begin
                prsc_cnt_q <= prsc_cnt_q + 8'd1;
            end
            case (state_q)
                s_idle: begin
                    if (start_i) begin
                        sreg_q    <= frame_i;
                        bit_cnt_q <= {nbytes_i, 3'b000}; // nbytes * 8
                        busy_o    <= 1'b1;
                        spi_csn_o <= 1'b0;
                        state_q   <= s_low;
                    end
                end
                s_low: begin
                    if (tick) begin
                        spi_clk_o <= 1'b1;
                        rdata_o   <= {rdata_o[30:0], spi_dat_i}; // sample on rising edge
                        state_q   <= s_high;
                    end
                end
                s_high: begin
                    if (tick) begin
                        spi_clk_o <= 1'b0;
                        sreg_q    <= {sreg_q[FRAME_BYTES*8-2:0], 1'b0}; // next bit out
                        bit_cnt_q <= bit_cnt_q - 7'd1;
                        state_q   <= (bit_cnt_q == 7'd1) ? s_end : s_low;
                    end
                end
                s_end: begin
                    if (tick) begin
                        spi_csn_o <= 1'b1; // no burst, always final
                        busy_o    <= 1'b0;
                        state_q   <= s_idle;
                    end
                end
                default: state_q <= s_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/xip_top.sv
// XIP SPI flash controller top level, connects register file, fetch engine, arbiter and PHY
`timescale 1ns/1ps
`default_nettype none

module xip_top #(
    parameter int FRAME_BYTES = 9 // cmd + 4 addr + 4 data bytes
) (
    input  wire                    clk_i,
    input  wire                    rstn_i,
    // control port
    input  wire xip_pkg::reg_idx_t ct_addr_i,
    input  wire                    ct_rden_i,
    input  wire                    ct_wren_i,
    input  wire xip_pkg::word_t    ct_data_i,
    output xip_pkg::word_t         ct_data_o,
    output logic                   ct_ack_o,
    // fetch port
    input  wire xip_pkg::word_t    acc_addr_i,
    input  wire                    acc_rden_i,
    input  wire                    acc_wren_i,
    output xip_pkg::word_t         acc_data_o,
    output logic                   acc_ack_o,
    output logic                   acc_err_o,
    // spi flash pins
    output logic                   spi_csn_o,
    output logic                   spi_clk_o,
    input  wire                    spi_dat_i,
    output logic                   spi_dat_o
);

    logic                     enable, xip_enable, fetch_active;
    xip_pkg::prsc_t           prsc;
    xip_pkg::nbytes_t         nbytes;
    xip_pkg::abytes_t         abytes;
    xip_pkg::cmd_t            rd_cmd;
    xip_pkg::page_t           page;
    logic                     direct_start, fetch_start, fetch_busy;
    logic                     phy_start, phy_busy;
    logic [FRAME_BYTES*8-1:0] direct_frame, fetch_frame, phy_frame;
    xip_pkg::word_t           phy_rdata;

    assign fetch_active = enable & xip_enable; // fetch runs only in xip mode

    xip_ctrl_regs #(.FRAME_BYTES(FRAME_BYTES)) i_ctrl_regs (
        .clk_i, .rstn_i, .ct_addr_i, .ct_rden_i, .ct_wren_i, .ct_data_i,
        .ct_data_o, .ct_ack_o,
        .phy_busy_i     (phy_busy),
        .xip_busy_i     (fetch_busy),
        .phy_rdata_i    (phy_rdata),
        .enable_o       (enable),
        .prsc_o         (prsc),
        .nbytes_o       (nbytes),
        .xip_enable_o   (xip_enable),
        .abytes_o       (abytes),
        .rd_cmd_o       (rd_cmd),
        .page_o         (page),
        .direct_start_o (direct_start),
        .direct_frame_o (direct_frame)
    );

    xip_fetch #(.FRAME_BYTES(FRAME_BYTES)) i_fetch (
        .clk_i, .rstn_i, .acc_addr_i, .acc_rden_i, .acc_wren_i,
        .acc_data_o, .acc_ack_o, .acc_err_o,
        .active_i    (fetch_active),
        .page_i      (page),
        .abytes_i    (abytes),
        .rd_cmd_i    (rd_cmd),
        .phy_busy_i  (phy_busy),
        .phy_rdata_i (phy_rdata),
        .busy_o      (fetch_busy),
        .start_o     (fetch_start),
        .frame_o     (fetch_frame)
    );

    xip_phy_arbiter #(.FRAME_BYTES(FRAME_BYTES)) i_arbiter (
        .clk_i, .rstn_i,
        .xip_enable_i   (xip_enable),
        .phy_busy_i     (phy_busy),
        .direct_start_i (direct_start),
        .direct_frame_i (direct_frame),
        .fetch_start_i  (fetch_start),
        .fetch_frame_i  (fetch_frame),
        .phy_start_o    (phy_start),
        .phy_frame_o    (phy_frame)
    );

    xip_spi_phy #(.FRAME_BYTES(FRAME_BYTES)) i_spi_phy (
        .clk_i, .rstn_i,
        .enable_i (enable),
        .prsc_i   (prsc),
        .nbytes_i (nbytes),
        .start_i  (phy_start),
        .frame_i  (phy_frame),
        .busy_o   (phy_busy),
        .rdata_o  (phy_rdata),
        .spi_csn_o, .spi_clk_o, .spi_dat_i, .spi_dat_o
    );

endmodule

`default_nettype wire

//--- sim/xip_flash_model.sv
// behavioral SPI flash for the testbench, answers read commands from a computed byte pattern
`timescale 1ns/1ps
`default_nettype none

module xip_flash_model (
    input  wire       spi_csn_i,
    input  wire       spi_clk_i,
    input  wire       spi_dat_i,  // from controller, sampled on rising sclk
    output logic      spi_dat_o,  // to controller, changes on falling sclk
    input  wire [1:0] abytes_i    // address bytes minus one
);

    localparam logic [7:0] read_cmd_c = 8'h03; // plain read

    int          bit_cnt;   // bits received since cs fell
    int          data_bit;  // index of the data bit going out
    int          addr_bits; // 8 .. 32
    logic [7:0]  cmd;
    logic [31:0] addr;
    logic [7:0]  cur_byte;
    logic        last_bit;  // last mosi bit, echoed inverted

    // content pattern, every address bit has an effect
    function automatic logic [7:0] flash_byte(input logic [31:0] a);
        return a[7:0] ^ {a[11:8], a[15:12]} ^ a[23:16] ^ {a[30:24], a[31]} ^ 8'h5a;
    endfunction

    assign addr_bits = 8 * (abytes_i + 1);

    initial spi_dat_o = 1'b0;

    // ----------------------------------------
    // frame start
    always @(negedge spi_csn_i) begin
        bit_cnt   = 0;
        cmd       = '0;
        addr      = '0;
        spi_dat_o = 1'b0; // first bit seen by the controller
    end

    always @(posedge spi_clk_i) begin
        if (!spi_csn_i) begin
            last_bit = spi_dat_i;
            if (bit_cnt < 8) begin
                cmd = {cmd[6:0], spi_dat_i};       // command phase
            end else if (bit_cnt < 8 + addr_bits) begin
                addr = {addr[30:0], spi_dat_i};    // address phase, msb first
            end
            bit_cnt = bit_cnt + 1;
        end
    end

    always @(negedge spi_clk_i) begin
        if (!spi_csn_i) begin
            if (cmd == read_cmd_c && bit_cnt >= 8 + addr_bits) begin
                data_bit  = bit_cnt - 8 - addr_bits;
                cur_byte  = flash_byte(addr + data_bit / 8); // consecutive bytes
                spi_dat_o = cur_byte[7 - data_bit % 8];
            end else begin
                spi_dat_o = ~last_bit; // unknown command, echo inverted
            end
        end
    end

endmodule

`default_nettype wire

//--- sim/xip_tb.sv
// testbench for the XIP flash controller running random register, direct, fetch and prescaler tests
`timescale 1ns/1ps
`default_nettype none

module xip_tb;

    localparam int clk_period_c = 20;
    localparam int n_regs_c     = 8;  // control register writes
    localparam int n_direct_c   = 6;  // direct transfers
    localparam int n_fetch_c    = 8;  // fetch reads
    localparam int n_prsc_c     = 5;  // prescaler sweeps
    localparam int max_prsc_c   = 4;
    // transfers x (72 bits + cs hold) x worst sclk period x 2 plus control traffic
    localparam int timeout_cycles_c =
        (n_direct_c + n_fetch_c + n_prsc_c) * 73 * (4 << max_prsc_c) * 2 + 5000;

    logic              clk, rstn;
    xip_pkg::reg_idx_t ct_addr;
    logic              ct_rden, ct_wren, ct_ack;
    xip_pkg::word_t    ct_wdata, ct_rdata;
    xip_pkg::word_t    acc_addr, acc_data;
    logic              acc_rden, acc_wren, acc_ack, acc_err;
    logic              spi_csn, spi_clk, mosi, miso;
    xip_pkg::abytes_t  flash_abytes;

    int  errors = 0;
    int  checks = 0;
    int  tests = 0;
    int  cycles = 0;
    int  csn_falls = 0;  // transfers seen at the pins
    time last_rise = 0;
    time sclk_period = 0;
    bit  have_rise = 1'b0;

    xip_top i_xip_top (
        .clk_i(clk), .rstn_i(rstn),
        .ct_addr_i(ct_addr), .ct_rden_i(ct_rden), .ct_wren_i(ct_wren),
        .ct_data_i(ct_wdata), .ct_data_o(ct_rdata), .ct_ack_o(ct_ack),
        .acc_addr_i(acc_addr), .acc_rden_i(acc_rden), .acc_wren_i(acc_wren),
        .acc_data_o(acc_data), .acc_ack_o(acc_ack), .acc_err_o(acc_err),
        .spi_csn_o(spi_csn), .spi_clk_o(spi_clk), .spi_dat_i(miso), .spi_dat_o(mosi)
    );

    xip_flash_model i_flash (
        .spi_csn_i(spi_csn), .spi_clk_i(spi_clk), .spi_dat_i(mosi),
        .spi_dat_o(miso), .abytes_i(flash_abytes)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period_c / 2) clk = ~clk;
    end

    // ----------------------------------------
    // watchdog and pin monitors
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= timeout_cycles_c) begin
            $display("timeout: run did not finish within %0d cycles", timeout_cycles_c);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    always @(negedge spi_csn) begin
        csn_falls = csn_falls + 1;
        have_rise = 1'b0; // period measured inside one frame only
    end

    always @(posedge spi_clk) begin
        if (have_rise) sclk_period = $time - last_rise;
        last_rise = $time;
        have_rise = 1'b1;
    end

    // ----------------------------------------
    // reference model
    function automatic logic [7:0] flash_byte(input logic [31:0] a);
        return a[7:0] ^ {a[11:8], a[15:12]} ^ a[23:16] ^ {a[30:24], a[31]} ^ 8'h5a;
    endfunction

    // fields that the control register keeps
    function automatic xip_pkg::word_t kept_mask();
        xip_pkg::word_t m;
        m = '0;
        m[xip_pkg::ctrl_enable_c]         = 1'b1;
        m[xip_pkg::ctrl_prsc_lo_c +: 3]   = 3'h7;
        m[xip_pkg::ctrl_nbytes_lo_c +: 4] = 4'hf;
        m[xip_pkg::ctrl_xip_enable_c]     = 1'b1;
        m[xip_pkg::ctrl_abytes_lo_c +: 2] = 2'h3;
        m[xip_pkg::ctrl_rd_cmd_lo_c +: 8] = 8'hff;
        m[xip_pkg::ctrl_page_lo_c +: 4]   = 4'hf;
        return m;
    endfunction

    // flash echoes the previous mosi bit inverted and starts with a zero
    function automatic xip_pkg::word_t echo_response(input logic [71:0] tx, input int nbits);
        xip_pkg::word_t rx;
        rx = '0;
        for (int k = 0; k < nbits; k++) begin
            rx = {rx[30:0], (k == 0) ? 1'b0 : ~tx[72 - k]};
        end
        return rx;
    endfunction

    // little-endian word at the word-aligned flash address
    function automatic xip_pkg::word_t expected_word(input xip_pkg::word_t addr,
                                                     input xip_pkg::abytes_t ab);
        xip_pkg::word_t a;
        a = {4'h0, addr[27:2], 2'b00};
        if (ab == 2'd2) a[31:24] = 8'h00; // 3 address bytes
        return {flash_byte(a + 3), flash_byte(a + 2), flash_byte(a + 1), flash_byte(a)};
    endfunction

    // ----------------------------------------
    // helpers start and end at a falling edge
    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks = checks + 1;
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
            errors = errors + 1;
        end
    endtask

    task automatic ct_write(input xip_pkg::reg_idx_t idx, input xip_pkg::word_t data);
        ct_addr  = idx;
        ct_wdata = data;
        ct_wren  = 1'b1;
        @(negedge clk);
        check(ct_ack, 1'b1, "write ack");
        check(ct_rdata, 32'h0, "read data on write");
        ct_wren  = 1'b0;
    endtask

    task automatic ct_read(input xip_pkg::reg_idx_t idx, output xip_pkg::word_t data);
        ct_addr = idx;
        ct_rden = 1'b1;
        @(negedge clk);
        check(ct_ack, 1'b1, "read ack");
        data    = ct_rdata; // valid with ack
        ct_rden = 1'b0;
    endtask

    task automatic set_ctrl(input logic en, input xip_pkg::prsc_t prsc, input xip_pkg::nbytes_t nb,
                            input logic xen, input xip_pkg::abytes_t ab, input xip_pkg::page_t pg);
        xip_pkg::word_t w;
        w = '0;
        w[xip_pkg::ctrl_enable_c]         = en;
        w[xip_pkg::ctrl_prsc_lo_c +: 3]   = prsc;
        w[xip_pkg::ctrl_nbytes_lo_c +: 4] = nb;
        w[xip_pkg::ctrl_xip_enable_c]     = xen;
        w[xip_pkg::ctrl_abytes_lo_c +: 2] = ab;
        w[xip_pkg::ctrl_rd_cmd_lo_c +: 8] = 8'h03; // flash read command
        w[xip_pkg::ctrl_page_lo_c +: 4]   = pg;
        ct_write(xip_pkg::reg_ctrl_c, w);
    endtask

    task automatic fetch_check(input xip_pkg::prsc_t prsc);
        xip_pkg::abytes_t ab;
        xip_pkg::page_t   pg;
        xip_pkg::word_t   addr;
        ab   = 2'($urandom_range(3, 2)); // address must fit
        pg   = 4'($urandom);
        addr = {pg, 28'($urandom)};
        flash_abytes = ab;
        set_ctrl(1'b1, prsc, 4'(ab + 6), 1'b1, ab, pg); // cmd + addr + 4 data bytes
        acc_addr = addr;
        acc_rden = 1'b1;
        do @(negedge clk); while (!acc_ack); // held until ack
        check(acc_data, expected_word(addr, ab), "fetch data");
        acc_rden = 1'b0;
        @(negedge clk);
        check(acc_ack, 1'b0, "ack one cycle");
    endtask

    task automatic report(input string name, input int errs_before);
        tests = tests + 1;
        $display("test %-18s %s, %0d errors", name,
                 (errors == errs_before) ? "ok" : "failed", errors - errs_before);
    endtask

    // ----------------------------------------
    // test sequence
    initial begin
        xip_pkg::word_t wdata, rd, lo, hi;
        xip_pkg::prsc_t prsc;
        xip_pkg::page_t pg;
        int             nb, start, falls_before;
        logic           got_ack;
        ct_addr = '0;
        ct_rden = 1'b0;
        ct_wren = 1'b0;
        ct_wdata = '0;
        acc_addr = '0;
        acc_rden = 1'b0;
        acc_wren = 1'b0;
        flash_abytes = 2'd3;
        rstn = 1'b0;
        void'($urandom(32'hfdfe_f0db));
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        start = errors;
        check(ct_ack, 1'b0, "ct_ack after reset");
        check(acc_ack | acc_err, 1'b0, "acc ack/err after reset");
        check({spi_csn, spi_clk}, 2'b10, "spi pins after reset");
        for (int i = 0; i < n_regs_c; i++) begin
            wdata = $urandom;
            ct_write(xip_pkg::reg_ctrl_c, wdata);
            ct_read(xip_pkg::reg_ctrl_c, rd);
            check(rd, wdata & kept_mask(), "control readback"); // busy bits zero
        end
        report("register readback", start);

        start = errors;
        for (int i = 0; i < n_direct_c; i++) begin
            prsc = 3'($urandom_range(2, 0));
            nb   = $urandom_range(9, 4);
            set_ctrl(1'b1, prsc, 4'(nb), 1'b0, 2'd0, 4'd0);
            lo = $urandom;
            hi = $urandom;
            if (hi[31:24] == 8'h03) hi[31:24] = 8'hc3; // keep it a non-read command
            ct_write(xip_pkg::reg_data_lo_c, lo);
            ct_write(xip_pkg::reg_data_hi_c, hi);
            @(negedge clk); // start pulse then busy
            ct_read(xip_pkg::reg_ctrl_c, rd);
            check(rd[xip_pkg::ctrl_phy_busy_c], 1'b1, "phy busy after start");
            while (rd[xip_pkg::ctrl_phy_busy_c]) ct_read(xip_pkg::reg_ctrl_c, rd);
            ct_read(xip_pkg::reg_data_lo_c, rd);
            check(rd, echo_response({hi, lo, 8'h00}, nb * 8), "direct rx data");
        end
        report("direct transfer", start);

        start = errors;
        for (int i = 0; i < n_fetch_c; i++) fetch_check(3'($urandom_range(2, 0)));
        report("fetch reads", start);

        start = errors;
        pg = 4'($urandom);
        set_ctrl(1'b1, 3'd0, 4'd9, 1'b1, 2'd3, pg);
        falls_before = csn_falls;
        acc_addr = {pg, 28'($urandom)};
        acc_wren = 1'b1;
        @(negedge clk);
        check(acc_err, 1'b0, "err one cycle after write");
        @(negedge clk);
        check(acc_err, 1'b1, "err two cycles after write");
        acc_wren = 1'b0;
        @(negedge clk);
        check(acc_err, 1'b0, "err is a single pulse");
        check(csn_falls, falls_before, "spi transfers on write");
        report("write error", start);

        start = errors;
        acc_addr = {pg ^ 4'h8, 28'($urandom)}; // other page
        acc_rden = 1'b1;
        got_ack  = 1'b0;
        repeat (50) begin
            @(negedge clk);
            got_ack = got_ack | acc_ack | acc_err;
        end
        acc_rden = 1'b0;
        check(got_ack, 1'b0, "answer outside page");
        check(csn_falls, falls_before, "spi transfers outside page");
        report("outside page", start);

        start = errors;
        for (int i = 0; i < n_prsc_c; i++) begin
            prsc = 3'($urandom_range(max_prsc_c, 0));
            sclk_period = 0;
            fetch_check(prsc);
            check(32'(sclk_period / clk_period_c), 4 << prsc, "sclk period in cycles");
        end
        report("prescaler", start);

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
hw/xip_pkg.sv
hw/xip_ctrl_regs.sv
hw/xip_fetch.sv
hw/xip_phy_arbiter.sv
hw/xip_spi_phy.sv
hw/xip_top.sv
sim/xip_flash_model.sv
sim/xip_tb.sv
